// File: logic/spi_cmd_decode.sv
`timescale 1ns/1ps

module spi_cmd_decode (
  input  logic clk,
  input  logic resetn,
  input  logic cmd_valid,
  output logic cmd_ready,
  input  logic [spi_engine_pkg::cmd_width-1:0] cmd,
  input  logic busy,
  output logic op_start,
  output logic [1:0] op_code,
  output logic op_sel,
  output logic [7:0] op_arg,
  output logic sdo_en,
  output logic sdi_en,
  output logic cpol,
  output logic cpha,
  output logic three_wire,
  output logic [7:0] clk_div
);

  logic [1:0] opcode;
  logic pop;
  logic is_write;

  assign opcode = cmd[13:12];
  assign is_write = (opcode == spi_engine_pkg::op_write);

  // op_start marks an operation that the executor has not yet taken.
  assign cmd_ready = !busy && !op_start;
  assign pop = cmd_valid && cmd_ready;

  always_ff @(posedge clk) begin
    if (!resetn)
      op_start <= 1'b0;
    else
      op_start <= pop && !is_write;
  end

  // fields stay put until the next forwarded command.
  always_ff @(posedge clk) begin
    if (pop && !is_write) begin
      op_code <= opcode;
      op_sel <= cmd[8];
      op_arg <= cmd[7:0];
      sdo_en <= cmd[8];
      sdi_en <= cmd[9];
    end
  end

  // register writes never reach the executor.
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cpha <= spi_engine_pkg::default_cfg[0];
      cpol <= spi_engine_pkg::default_cfg[1];
      three_wire <= spi_engine_pkg::default_cfg[2];
      clk_div <= spi_engine_pkg::default_clk_div;
    end else if (pop && is_write) begin
      if (cmd[8] == spi_engine_pkg::reg_config) begin
        cpha <= cmd[0];
        cpol <= cmd[1];
        three_wire <= cmd[2];
      end else begin
        clk_div <= cmd[7:0];
      end
    end
  end

endmodule

// File: logic/spi_engine.sv
`timescale 1ns/1ps

module spi_engine (
  input  logic clk,
  input  logic resetn,
  input  logic cmd_valid,
  output logic cmd_ready,
  input  logic [spi_engine_pkg::cmd_width-1:0] cmd,
  input  logic sdo_valid,
  output logic sdo_ready,
  input  logic [spi_engine_pkg::data_width-1:0] sdo_data,
  output logic result_valid,
  input  logic result_ready,
  output logic [spi_engine_pkg::data_width-1:0] result_data,
  output logic result_sync,
  output logic sclk,
  output logic sdo,
  output logic sdo_t,
  input  logic sdi,
  output logic [spi_engine_pkg::num_cs-1:0] cs,
  output logic three_wire,
  output logic active
);

  logic q_cmd_valid, q_cmd_ready;
  logic [spi_engine_pkg::cmd_width-1:0] q_cmd;
  logic q_sdo_valid, q_sdo_ready;
  logic [spi_engine_pkg::data_width-1:0] q_sdo;
  logic res_push_valid, res_push_ready;
  logic [spi_engine_pkg::result_width-1:0] res_push_data, res_out;
  logic busy, op_start, op_sel, sdo_en, sdi_en, cpol, cpha;
  logic [1:0] op_code;
  logic [7:0] op_arg, clk_div;
  logic word_strobe, sync_strobe, result_space;
  logic [spi_engine_pkg::data_width-1:0] word_data;

  assign result_space = !res_push_valid && res_push_ready; // room for one more entry.
  assign result_data = res_out[spi_engine_pkg::data_width-1:0];
  assign result_sync = res_out[spi_engine_pkg::data_width];

  always_ff @(posedge clk) begin
    if (!resetn)
      active <= 1'b0;
    else if (cmd_valid && cmd_ready)
      active <= 1'b1;
    else if (result_valid && result_ready && result_sync)
      active <= 1'b0;
  end

  stream_fifo #(
    .payload_t(logic [spi_engine_pkg::cmd_width-1:0]),
    .depth(spi_engine_pkg::cmd_depth)
  ) cmd_fifo (.clk, .resetn, .in_valid(cmd_valid), .in_ready(cmd_ready), .in_data(cmd),
    .out_valid(q_cmd_valid), .out_ready(q_cmd_ready), .out_data(q_cmd));

  stream_fifo #(
    .payload_t(logic [spi_engine_pkg::data_width-1:0]),
    .depth(spi_engine_pkg::sdo_depth)
  ) sdo_fifo (.clk, .resetn, .in_valid(sdo_valid), .in_ready(sdo_ready), .in_data(sdo_data),
    .out_valid(q_sdo_valid), .out_ready(q_sdo_ready), .out_data(q_sdo));

  stream_fifo #(
    .payload_t(logic [spi_engine_pkg::result_width-1:0]),
    .depth(spi_engine_pkg::result_depth)
  ) result_fifo (.clk, .resetn, .in_valid(res_push_valid), .in_ready(res_push_ready),
    .in_data(res_push_data), .out_valid(result_valid), .out_ready(result_ready),
    .out_data(res_out));

  spi_cmd_decode decode0 (.clk, .resetn, .cmd_valid(q_cmd_valid), .cmd_ready(q_cmd_ready),
    .cmd(q_cmd), .busy, .op_start, .op_code, .op_sel, .op_arg, .sdo_en, .sdi_en, .cpol,
    .cpha, .three_wire, .clk_div);

  spi_exec exec0 (.clk, .resetn, .op_start, .op_code, .op_sel, .op_arg, .sdo_en, .sdi_en,
    .cpol, .cpha, .clk_div, .busy, .sdo_valid(q_sdo_valid), .sdo_ready(q_sdo_ready),
    .sdo_data(q_sdo), .result_space, .word_strobe, .sync_strobe, .word_data, .sclk, .sdo,
    .sdo_t, .sdi, .cs);

  spi_result result0 (.clk, .resetn, .word_strobe, .sync_strobe, .word_data,
    .push_valid(res_push_valid), .push_ready(res_push_ready), .push_data(res_push_data));

endmodule

// File: logic/spi_engine_pkg.sv
package spi_engine_pkg;

  // spi word and command sizes.
  localparam int data_width = 8;
  localparam int num_cs = 2;
  localparam int cmd_width = 16;

  // half-period counter width for one word.
  localparam int half_cnt_width = $clog2(2 * data_width);

  // opcodes, found in cmd[13:12].
  localparam logic [1:0] op_transfer = 2'b00;
  localparam logic [1:0] op_chipselect = 2'b01;
  localparam logic [1:0] op_write = 2'b10;
  localparam logic [1:0] op_misc = 2'b11;

  // cmd[8] under op_misc.
  localparam logic misc_sync = 1'b0;
  localparam logic misc_sleep = 1'b1;

  // cmd[8] under op_write.
  localparam logic reg_clk_div = 1'b0;
  localparam logic reg_config = 1'b1;

  // values after reset.
  localparam logic [7:0] default_clk_div = 8'd1;
  localparam logic [2:0] default_cfg = 3'b000; // {three_wire, cpol, cpha}.

  // result entry is {sync tag, data}.
  localparam int result_width = data_width + 1;

  // queue depths, powers of two.
  localparam int cmd_depth = 4;
  localparam int sdo_depth = 4;
  localparam int result_depth = 8;

endpackage

// File: logic/spi_exec.sv
`timescale 1ns/1ps

module spi_exec (
  input  logic clk,
  input  logic resetn,
  input  logic op_start,
  input  logic [1:0] op_code,
  input  logic op_sel,
  input  logic [7:0] op_arg,
  input  logic sdo_en,
  input  logic sdi_en,
  input  logic cpol,
  input  logic cpha,
  input  logic [7:0] clk_div,
  output logic busy,
  input  logic sdo_valid,
  output logic sdo_ready,
  input  logic [spi_engine_pkg::data_width-1:0] sdo_data,
  input  logic result_space,
  output logic word_strobe,
  output logic sync_strobe,
  output logic [spi_engine_pkg::data_width-1:0] word_data,
  output logic sclk,
  output logic sdo,
  output logic sdo_t,
  input  logic sdi,
  output logic [spi_engine_pkg::num_cs-1:0] cs
);

  typedef enum logic [2:0] {
    st_idle,
    st_load,
    st_shift,
    st_cs,
    st_sleep,
    st_sync
  } state_t;

  state_t state;
  logic [7:0] div_cnt;
  logic [spi_engine_pkg::half_cnt_width+7:0] cnt; // {word, half-period}.
  logic [spi_engine_pkg::data_width-1:0] shreg;
  logic [7:0] word_idx;
  logic [spi_engine_pkg::half_cnt_width-1:0] half_idx;
  logic run;
  logic tick;
  logic word_end;
  logic space_ok;
  logic io_ok;

  assign word_idx = cnt[spi_engine_pkg::half_cnt_width+7:spi_engine_pkg::half_cnt_width];
  assign half_idx = cnt[spi_engine_pkg::half_cnt_width-1:0];

  assign run = (state == st_shift) || (state == st_cs) || (state == st_sleep);
  assign tick = run && (div_cnt == 8'd0); // last cycle of a half period.
  assign word_end = tick && (&half_idx);

  // a strobe in flight has not reached the result flag yet.
  assign space_ok = result_space && !word_strobe && !sync_strobe;
  assign io_ok = (!sdo_en || sdo_valid) && (!sdi_en || space_ok);
  assign sdo_ready = (state == st_load) && sdo_en && io_ok;

  assign busy = (state != st_idle);
  assign sdo = shreg[spi_engine_pkg::data_width-1];
  assign sdo_t = !(sdo_en && ((state == st_load) || (state == st_shift)));
  assign sclk = (state == st_shift) ? (cpol ^ cpha ^ half_idx[0]) : cpol;

  always_ff @(posedge clk) begin
    if (!resetn)
      div_cnt <= 8'd0;
    else if (!run || div_cnt == 8'd0)
      div_cnt <= clk_div;
    else
      div_cnt <= div_cnt - 8'd1;
  end

  always_ff @(posedge clk) begin
    if (state == st_idle)
      cnt <= '0;
    else if (tick)
      cnt <= cnt + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= st_idle;
      cs <= '1;
      word_strobe <= 1'b0;
      sync_strobe <= 1'b0;
    end else begin
      word_strobe <= 1'b0;
      sync_strobe <= 1'b0;
      case (state)
        st_idle: begin
          if (op_start) begin
            case (op_code)
              spi_engine_pkg::op_transfer: state <= st_load;
              spi_engine_pkg::op_chipselect: state <= st_cs;
              spi_engine_pkg::op_misc:
                state <= (op_sel == spi_engine_pkg::misc_sleep) ? st_sleep : st_sync;
              default: state <= st_idle;
            endcase
          end
        end
        st_load: begin
          if (io_ok)
            state <= st_shift; // hold sclk at cpol until data and space are there.
        end
        st_shift: begin
          if (word_end) begin
            word_strobe <= sdi_en;
            state <= (word_idx == op_arg) ? st_idle : st_load;
          end
        end
        st_cs: begin
          if (tick && half_idx[1:0] == 2'd1)
            cs <= op_arg[spi_engine_pkg::num_cs-1:0];
          if (tick && half_idx[1:0] == 2'd3)
            state <= st_idle; // settle time after the change.
        end
        st_sleep: begin
          if (word_end && word_idx == op_arg)
            state <= st_idle; // 16 half periods per count.
        end
        st_sync: begin
          if (space_ok) begin
            sync_strobe <= 1'b1;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // msb out first, sdi shifts in at the end of each bit.
  always_ff @(posedge clk) begin
    if (state == st_load && io_ok)
      shreg <= sdo_en ? sdo_data : '0;
    else if (state == st_shift && tick && half_idx[0])
      shreg <= {shreg[spi_engine_pkg::data_width-2:0], sdi};
  end

  always_ff @(posedge clk) begin
    if (state == st_shift && word_end)
      word_data <= {shreg[spi_engine_pkg::data_width-2:0], sdi};
    else if (state == st_sync && space_ok)
      word_data <= op_arg;
  end

endmodule

// File: logic/spi_result.sv
`timescale 1ns/1ps

module spi_result (
  input  logic clk,
  input  logic resetn,
  input  logic word_strobe,
  input  logic sync_strobe,
  input  logic [spi_engine_pkg::data_width-1:0] word_data,
  output logic push_valid,
  input  logic push_ready,
  output logic [spi_engine_pkg::result_width-1:0] push_data
);

  logic strobe;

  assign strobe = word_strobe || sync_strobe;

  // push_valid doubles as the outstanding-entry flag.
  always_ff @(posedge clk) begin
    if (!resetn)
      push_valid <= 1'b0;
    else if (strobe)
      push_valid <= 1'b1;
    else if (push_ready)
      push_valid <= 1'b0;
  end

  // tag sits above the data bits.
  always_ff @(posedge clk) begin
    if (strobe)
      push_data <= {sync_strobe, word_data};
  end

endmodule

// File: logic/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int depth = 4
) (
  input  logic     clk,
  input  logic     resetn,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  payload_t mem [depth];
  logic [$clog2(depth)-1:0] wr_ptr;
  logic [$clog2(depth)-1:0] rd_ptr;
  logic [$clog2(depth):0] count;
  logic [$clog2(depth):0] count_next;
  logic push;
  logic pop;

  assign push = in_valid && in_ready;
  assign pop = out_valid && out_ready;
  assign out_valid = (count != '0);
  assign out_data = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (push && !pop)
      count_next = count + 1'b1;
    else if (pop && !push)
      count_next = count - 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      in_ready <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two.
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count_next;
      in_ready <= (count_next != depth[$clog2(depth):0]);
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

endmodule

// File: run.sh
#!/bin/sh
# build and run the spi engine testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module spi_engine_tb \
  -f spi_engine.f -o spi_engine_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/spi_engine_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1

// File: spi_engine.f
logic/spi_engine_pkg.sv
logic/stream_fifo.sv
logic/spi_cmd_decode.sv
logic/spi_exec.sv
logic/spi_result.sv
logic/spi_engine.sv
tests/spi_engine_props.sv
tests/spi_engine_tb.sv

// File: tests/spi_engine_props.sv
`timescale 1ns/1ps

module spi_engine_props (
  input logic clk,
  input logic resetn,
  input logic cmd_valid,
  input logic cmd_ready,
  input logic [spi_engine_pkg::cmd_width-1:0] cmd,
  input logic sdo_valid,
  input logic sdo_ready,
  input logic [spi_engine_pkg::data_width-1:0] sdo_data,
  input logic result_valid,
  input logic result_ready,
  input logic [spi_engine_pkg::data_width-1:0] result_data,
  input logic result_sync,
  input logic sdo_t,
  input logic [spi_engine_pkg::num_cs-1:0] cs,
  input logic busy,
  input logic [1:0] op_code
);

  // a stalled beat keeps valid and payload.
  cmd_hold: assert property (@(posedge clk) disable iff (!resetn)
    (cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(cmd)))
    else $error("command beat changed while stalled");

  sdo_hold: assert property (@(posedge clk) disable iff (!resetn)
    (sdo_valid && !sdo_ready) |=> (sdo_valid && $stable(sdo_data)))
    else $error("sdo beat changed while stalled");

  result_hold: assert property (@(posedge clk) disable iff (!resetn)
    (result_valid && !result_ready) |=>
      (result_valid && $stable(result_data) && $stable(result_sync)))
    else $error("result beat changed while stalled");

  reset_state: assert property (@(posedge clk) !resetn |=> (cs == '1 && !result_valid))
    else $error("cs or result_valid wrong after reset");

  // the data pin is only driven inside a transfer.
  sdo_t_idle: assert property (@(posedge clk) disable iff (!resetn)
    (!busy || op_code != spi_engine_pkg::op_transfer) |-> sdo_t)
    else $error("sdo_t low outside a transfer");

endmodule

bind spi_engine spi_engine_props props0 (.clk, .resetn, .cmd_valid, .cmd_ready, .cmd,
  .sdo_valid, .sdo_ready, .sdo_data, .result_valid, .result_ready, .result_data,
  .result_sync, .sdo_t, .cs, .busy, .op_code);

// File: tests/spi_engine_tb.sv
`timescale 1ns/1ps

module spi_engine_tb;

  localparam int num_programs = 12;

  logic clk;
  logic resetn;
  logic cmd_valid, cmd_ready;
  logic [spi_engine_pkg::cmd_width-1:0] cmd;
  logic sdo_valid, sdo_ready;
  logic [spi_engine_pkg::data_width-1:0] sdo_data;
  logic result_valid, result_ready, result_sync;
  logic [spi_engine_pkg::data_width-1:0] result_data;
  logic sclk, sdo, sdo_t, sdi, three_wire, active;
  logic [spi_engine_pkg::num_cs-1:0] cs;

  logic [15:0] cmd_q[$];
  logic [7:0] sdo_q[$];
  logic [8:0] exp_q[$]; // {sync tag, data}.
  logic [15:0] hist; // sdo history with the newest bit at 0.
  logic [3:0] sdi_delay;
  logic [1:0] cur_cs, prev_cs;
  logic cs_done;
  logic [2:0] cur_cfg, prev_cfg;
  logic has_tx;
  int seed = 93780;
  int stall;
  int cycles = 0;
  int limit = 200;

  spi_engine dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout: the engine made no progress for too long (%0d cycles)", cycles);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [15:0] make_cmd(logic [1:0] op, logic rx, logic sel, logic [7:0] arg);
    return {2'b00, op, 2'b00, rx, sel, arg};
  endfunction

  function automatic int rand_below(int n);
    int r;
    r = $random(seed) & 32'h7fffffff;
    return r % n;
  endfunction

  task automatic check(string name, int expected, int actual);
    if (expected != actual) begin
      $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // each program writes divider, config and chip select, then random work and a sync.
  task automatic build_program(int p);
    logic [7:0] div;
    logic [7:0] b;
    int items;
    int kind;
    int words;
    int est;
    div = 8'(rand_below(6));
    prev_cs = cur_cs;
    prev_cfg = cur_cfg;
    cur_cs = 2'(rand_below(4));
    cs_done = 1'b0;
    cur_cfg = {rand_below(2) == 1, 2'(p)}; // walks all cpol/cpha pairs.
    sdi_delay = 4'(div + 8'd1); // half an sclk period.
    has_tx = 1'b0;
    est = 64 * (div + 1);
    cmd_q.push_back(make_cmd(spi_engine_pkg::op_write, 1'b0, spi_engine_pkg::reg_clk_div, div));
    cmd_q.push_back(make_cmd(spi_engine_pkg::op_write, 1'b0, spi_engine_pkg::reg_config,
      {5'd0, cur_cfg}));
    cmd_q.push_back(make_cmd(spi_engine_pkg::op_chipselect, 1'b0, 1'b0, {6'd0, cur_cs}));
    items = 1 + rand_below(4);
    for (int i = 0; i < items; i++) begin
      kind = rand_below(4);
      words = 1 + rand_below(4);
      est += words * 16 * (div + 1) + 8;
      if (kind == 3) begin
        cmd_q.push_back(make_cmd(spi_engine_pkg::op_misc, 1'b0, spi_engine_pkg::misc_sleep,
          8'(words - 1)));
      end else begin
        // kind 2 sends without receiving.
        cmd_q.push_back(make_cmd(spi_engine_pkg::op_transfer, kind != 2, 1'b1, 8'(words - 1)));
        has_tx = 1'b1;
        for (int w = 0; w < words; w++) begin
          b = 8'(rand_below(256));
          sdo_q.push_back(b);
          if (kind != 2)
            exp_q.push_back({1'b0, b});
        end
      end
    end
    b = 8'(rand_below(256));
    cmd_q.push_back(make_cmd(spi_engine_pkg::op_misc, 1'b0, spi_engine_pkg::misc_sync, b));
    exp_q.push_back({1'b1, b});
    limit = cycles + 4 * est + 3000;
  endtask

  task automatic one_cycle();
    logic cmd_fire;
    logic sdo_fire;
    @(negedge clk);
    cmd_fire = cmd_valid && cmd_ready;
    sdo_fire = sdo_valid && sdo_ready;
    if (result_valid && result_ready) begin
      if (exp_q.size() == 0) begin
        $display("result stream returned an entry no command asked for");
        $display(">>> FAIL");
        $fatal(1, "unexpected result");
      end else begin
        check("result entry", int'(exp_q[0]), int'({result_sync, result_data}));
        if (result_sync)
          check("active before sync leaves", 1, int'(active));
        void'(exp_q.pop_front());
      end
    end
    if (cs == cur_cs)
      cs_done = 1'b1; // the chip-select command has taken effect.
    if (cs_done)
      check("cs after change", int'(cur_cs), int'(cs));
    else
      check("cs before change", int'(prev_cs), int'(cs));
    if (sdo_t && sclk != cur_cfg[1] && sclk != prev_cfg[1])
      check("sclk idle level", int'(cur_cfg[1]), int'(sclk));
    if (!has_tx)
      check("sdo_t outside transmit", 1, int'(sdo_t));
    @(posedge clk);
    #1;
    if (cmd_fire)
      void'(cmd_q.pop_front());
    if (sdo_fire)
      void'(sdo_q.pop_front());
    cmd_valid = (cmd_q.size() > 0);
    cmd = (cmd_q.size() > 0) ? cmd_q[0] : 16'h0;
    sdo_valid = (sdo_q.size() > 0);
    sdo_data = (sdo_q.size() > 0) ? sdo_q[0] : 8'h0;
    if (stall > 0)
      stall = stall - 1;
    else if (rand_below(64) == 0)
      stall = 40 + rand_below(80); // long result back-pressure.
    result_ready = (stall == 0) && (rand_below(4) != 0);
    hist = {hist[14:0], sdo};
    sdi = hist[sdi_delay]; // loopback slave.
  endtask

  task automatic run_program(int p);
    build_program(p);
    while (exp_q.size() > 0)
      one_cycle();
    @(negedge clk);
    check("active after sync", 0, int'(active));
    check("cs after program", int'(cur_cs), int'(cs));
    check("sclk idle at cpol", int'(cur_cfg[1]), int'(sclk));
    check("three_wire", int'(cur_cfg[2]), int'(three_wire));
    check("sdo_t idle", 1, int'(sdo_t));
    check("sdo bytes consumed", 0, sdo_q.size());
  endtask

  initial begin
    resetn = 1'b0;
    cmd_valid = 1'b0;
    cmd = '0;
    sdo_valid = 1'b0;
    sdo_data = '0;
    result_ready = 1'b0;
    sdi = 1'b0;
    hist = '0;
    sdi_delay = 4'd1;
    stall = 0;
    cur_cs = '1;
    prev_cs = '1;
    cs_done = 1'b0;
    cur_cfg = spi_engine_pkg::default_cfg;
    prev_cfg = spi_engine_pkg::default_cfg;
    has_tx = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    resetn = 1'b1;
    check("cs after reset", 3, int'(cs));
    for (int p = 0; p < num_programs; p++)
      run_program(p);
    $display(">>> PASS");
    $finish;
  end

endmodule
